/* Makefile */
TOP = execute_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f build.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* alu.sv */
`timescale 1ns/1ps

module alu import exec_pkg::*; (
  input  op_t   op,
  input  word_t operand_a,
  input  word_t operand_b,
  input  word_t pc,
  output word_t result
);

  logic [4:0] shamt;

  assign shamt = operand_b[4:0];

  always_comb begin
    case (op)
      op_sub:  result = operand_a - operand_b;
      op_and:  result = operand_a & operand_b;
      op_or:   result = operand_a | operand_b;
      op_xor:  result = operand_a ^ operand_b;
      op_sll:  result = operand_a << shamt;
      op_srl:  result = operand_a >> shamt;
      op_sra:  result = word_t'($signed(operand_a) >>> shamt);
      op_slt:  result = {31'b0, $signed(operand_a) < $signed(operand_b)};
      op_sltu: result = {31'b0, operand_a < operand_b};
      op_lui:  result = operand_b;        // immediate arrives on b
      op_jal:  result = pc + 32'd4;       // link value
      default: result = operand_a + operand_b;
    endcase
  end

endmodule

/* branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import exec_pkg::*; (
  input  op_t   op,
  input  word_t operand_a,
  input  word_t operand_b,
  input  word_t pc,
  input  word_t imm,
  output logic  taken,
  output word_t target
);

  logic lt_signed;

  assign lt_signed = $signed(operand_a) < $signed(operand_b);

  always_comb begin
    case (op)
      op_beq:  taken = (operand_a == operand_b);
      op_bne:  taken = (operand_a != operand_b);
      op_blt:  taken = lt_signed;
      op_bge:  taken = !lt_signed;
      op_jal:  taken = 1'b1;  // unconditional
      default: taken = 1'b0;
    endcase
  end

  // jal and branches share the pc-relative target
  assign target = pc + imm;

endmodule

/* build.f */
exec_pkg.sv
register_file.sv
forwarding.sv
alu.sv
branch_unit.sv
divider.sv
execute_stage.sv
execute_top.sv
tb_clock.sv
execute_tb.sv

/* divider.sv */
`timescale 1ns/1ps

module divider import exec_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  start,
  input  word_t dividend,
  input  word_t divisor,
  output word_t quotient,
  output word_t remainder,
  output logic  ready
);

  typedef enum logic [1:0] {
    div_idle,
    div_busy,
    div_done
  } div_state_t;

  div_state_t state;
  logic [4:0] count;
  word_t      rem_q;
  word_t      quot_q;
  word_t      divisor_q;
  logic [32:0] shifted;
  logic [32:0] diff;
  logic        fits;

  // restoring step, one quotient bit
  assign shifted = {rem_q, quot_q[31]};
  assign diff    = shifted - {1'b0, divisor_q};
  assign fits    = !diff[32];  // zero divisor always fits

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= div_idle;
      count <= '0;
    end else begin
      case (state)
        div_idle: begin
          count <= '0;
          if (start) state <= div_busy;
        end
        div_busy: begin
          count <= count + 5'd1;
          if (count == 5'd31) state <= div_done;
        end
        default: begin
          if (!start) state <= div_idle;  // wait for the stage to take it
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if ((state == div_idle) && start) begin
      rem_q     <= '0;
      quot_q    <= dividend;
      divisor_q <= divisor;
    end else if (state == div_busy) begin
      rem_q  <= fits ? diff[31:0] : shifted[31:0];
      quot_q <= {quot_q[30:0], fits};
    end
  end

  assign quotient  = quot_q;
  assign remainder = rem_q;
  assign ready     = (state == div_done);

endmodule

/* exec_pkg.sv */
package exec_pkg;

  typedef logic [31:0] word_t;     // data word, pc and immediates
  typedef logic [4:0] reg_addr_t;  // x0..x31

  typedef enum logic [4:0] {
    op_add  = 5'd0,
    op_sub  = 5'd1,
    op_and  = 5'd2,
    op_or   = 5'd3,
    op_xor  = 5'd4,
    op_sll  = 5'd5,
    op_srl  = 5'd6,
    op_sra  = 5'd7,
    op_slt  = 5'd8,
    op_sltu = 5'd9,
    op_lui  = 5'd10,
    op_jal  = 5'd11,
    op_beq  = 5'd12,  // conditional branches
    op_bne  = 5'd13,
    op_blt  = 5'd14,
    op_bge  = 5'd15,
    op_divu = 5'd16,  // multi-cycle
    op_remu = 5'd17
  } op_t;

endpackage

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import exec_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      issue_valid,
  input  op_t       issue_op,
  input  reg_addr_t issue_rd,
  input  word_t     issue_imm,
  input  word_t     issue_pc,
  input  logic      issue_use_imm,
  input  word_t     operand_a,
  input  word_t     operand_b,
  input  word_t     alu_result,
  input  logic      branch_taken,
  input  word_t     branch_target,
  input  word_t     div_quotient,
  input  word_t     div_remainder,
  input  logic      div_ready,
  output logic      div_start,
  output word_t     unit_b,
  output logic      result_valid,
  output reg_addr_t result_rd,
  output word_t     result_data,
  output logic      redirect,
  output word_t     redirect_pc,
  output logic      stall
);

  logic  live;
  logic  is_div;
  logic  is_branch;
  logic  accept;
  logic  writes_rd;
  word_t result_sel;

  // the instruction right behind a redirect is squashed
  assign live      = issue_valid && !redirect;
  assign is_div    = (issue_op == op_divu) || (issue_op == op_remu);
  assign is_branch = (issue_op == op_beq) || (issue_op == op_bne) ||
                     (issue_op == op_blt) || (issue_op == op_bge);

  assign div_start = live && is_div && !div_ready;
  assign stall     = div_start;  // held until the quotient is ready
  assign accept    = issue_valid && !stall;
  assign writes_rd = !is_branch && (issue_rd != '0);

  assign unit_b = issue_use_imm ? issue_imm : operand_b;

  always_comb begin
    case (issue_op)
      op_divu: result_sel = div_quotient;
      op_remu: result_sel = div_remainder;
      op_lui:  result_sel = issue_imm;
      default: result_sel = alu_result;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      result_valid <= 1'b0;
      redirect     <= 1'b0;
    end else begin
      result_valid <= accept && live && writes_rd;
      redirect     <= accept && live && branch_taken;
    end
  end

  // write-back payload
  always_ff @(posedge clock) begin
    result_rd   <= issue_rd;
    result_data <= result_sel;
    redirect_pc <= branch_target;
  end

endmodule

/* execute_tb.sv */
`timescale 1ns/1ps

module execute_tb import exec_pkg::*; ();

  localparam int LOADS = 31;
  localparam int RANDOM_OPS = 60;
  localparam int FWD_ROUNDS = 12;
  localparam int BRANCH_ROUNDS = 16;
  localparam int DIV_ROUNDS = 12;
  // three instructions per round in the directed tests
  localparam int ISSUED = 1 + LOADS + RANDOM_OPS + 3 * (FWD_ROUNDS + BRANCH_ROUNDS + DIV_ROUNDS);
  localparam int CYCLE_LIMIT = 40 * ISSUED;

  logic      clock;
  logic      reset;
  logic      issue_valid;
  op_t       issue_op;
  reg_addr_t issue_rs1;
  reg_addr_t issue_rs2;
  reg_addr_t issue_rd;
  word_t     issue_imm;
  word_t     issue_pc;
  logic      issue_use_imm;
  logic      result_valid;
  reg_addr_t result_rd;
  word_t     result_data;
  logic      redirect;
  word_t     redirect_pc;
  logic      stall;

  word_t     model_regs [32];
  word_t     pc;
  logic      in_shadow;
  logic      next_valid;  // staged with the inputs
  logic      next_redirect;
  reg_addr_t next_rd;
  word_t     next_data;
  word_t     next_target;
  logic      cur_valid;   // taken on acceptance
  logic      cur_redirect;
  reg_addr_t cur_rd;
  word_t     cur_data;
  word_t     cur_target;
  logic      armed;
  int        check_count;
  int        error_count;
  int        test_count;
  int        last_checks;
  int        last_errors;
  int        cycle_count;

  tb_clock u_clock (
    .clock (clock),
    .reset (reset)
  );

  execute_top UUT (
    .clock         (clock),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_rs1     (issue_rs1),
    .issue_rs2     (issue_rs2),
    .issue_rd      (issue_rd),
    .issue_imm     (issue_imm),
    .issue_pc      (issue_pc),
    .issue_use_imm (issue_use_imm),
    .result_valid  (result_valid),
    .result_rd     (result_rd),
    .result_data   (result_data),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .stall         (stall)
  );

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic word_t expected_result(input op_t op, input word_t a, input word_t rb,
      input word_t imm, input word_t at_pc, input logic use_imm, input reg_addr_t rd,
      output logic writes, output logic taken, output word_t target);
    word_t      b;
    word_t      res;
    logic [4:0] sh;
    b      = use_imm ? imm : rb;
    sh     = b[4:0];
    res    = '0;
    writes = (rd != 5'd0);
    taken  = 1'b0;
    target = at_pc + imm;
    case (op)
      op_add:  res = a + b;
      op_sub:  res = a - b;
      op_and:  res = a & b;
      op_or:   res = a | b;
      op_xor:  res = a ^ b;
      op_sll:  res = a << sh;
      op_srl:  res = a >> sh;
      op_sra:  res = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      op_slt:  res = {31'b0, $signed(a) < $signed(b)};
      op_sltu: res = {31'b0, a < b};
      op_lui:  res = imm;
      op_jal: begin
        res   = at_pc + 32'd4;
        taken = 1'b1;
      end
      op_divu: res = (b == 0) ? 32'hffff_ffff : a / b;
      op_remu: res = (b == 0) ? a : a % b;
      default: begin
        // branches compare the two registers and write nothing
        writes = 1'b0;
        case (op)
          op_beq:  taken = (a == rb);
          op_bne:  taken = (a != rb);
          op_blt:  taken = $signed(a) < $signed(rb);
          default: taken = $signed(a) >= $signed(rb);
        endcase
      end
    endcase
    return res;
  endfunction

  task automatic issue_instr(input op_t op, input reg_addr_t rs1, input reg_addr_t rs2,
                             input reg_addr_t rd, input word_t imm, input logic use_imm);
    word_t res;
    word_t target;
    logic  writes;
    logic  taken;
    logic  squashed;
    int    stall_cycles;
    int    want_stall;
    @(negedge clock);
    squashed = in_shadow;
    res = expected_result(op, model_regs[rs1], model_regs[rs2], imm, pc, use_imm, rd,
                          writes, taken, target);
    next_valid    = writes && !squashed;
    next_rd       = rd;
    next_data     = res;
    next_redirect = taken && !squashed;
    next_target   = target;
    issue_valid   = 1'b1;
    issue_op      = op;
    issue_rs1     = rs1;
    issue_rs2     = rs2;
    issue_rd      = rd;
    issue_imm     = imm;
    issue_pc      = pc;
    issue_use_imm = use_imm;
    want_stall = (((op == op_divu) || (op == op_remu)) && !squashed) ? 33 : 0;
    stall_cycles = 0;
    @(posedge clock);
    while (stall) begin
      stall_cycles++;  // inputs held meanwhile
      @(posedge clock);
    end
    check_value("stall cycles", 32'(stall_cycles), 32'(want_stall));
    if (next_valid) model_regs[rd] = res;
    in_shadow = next_redirect;
    pc = next_redirect ? target : pc + 32'd4;
  endtask

  task automatic idle_cycle();
    @(negedge clock);
    issue_valid   = 1'b0;
    next_valid    = 1'b0;
    next_redirect = 1'b0;
    @(posedge clock);
    in_shadow = 1'b0;  // shadow used up by the bubble
  endtask

  task automatic report_test(input string name);
    idle_cycle();
    @(negedge clock);
    test_count++;
    $display("test %s done: %0d checks, %0d errors", name, check_count - last_checks,
             error_count - last_errors);
    last_checks = check_count;
    last_errors = error_count;
  endtask

  // compare process, one cycle after each edge
  always @(posedge clock) begin
    if (reset && armed) begin
      check_value("result_valid", 32'(result_valid), 32'(cur_valid));
      if (cur_valid) begin
        check_value("result_rd", 32'(result_rd), 32'(cur_rd));
        check_value("result_data", result_data, cur_data);
      end
      check_value("redirect", 32'(redirect), 32'(cur_redirect));
      if (cur_redirect) check_value("redirect_pc", redirect_pc, cur_target);
    end
    armed = reset;
    if (issue_valid && !stall) begin
      cur_valid    = next_valid;
      cur_rd       = next_rd;
      cur_data     = next_data;
      cur_redirect = next_redirect;
      cur_target   = next_target;
    end else begin
      cur_valid    = 1'b0;
      cur_redirect = 1'b0;
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    reg_addr_t prod;
    reg_addr_t cons;
    reg_addr_t src;
    reg_addr_t shadow_rd;
    op_t       bop;
    op_t       shadow_op;
    word_t     divisor;
    void'($urandom(32'hd63f));
    issue_valid   = 1'b0;
    issue_op      = op_add;
    issue_rs1     = '0;
    issue_rs2     = '0;
    issue_rd      = '0;
    issue_imm     = '0;
    issue_pc      = '0;
    issue_use_imm = 1'b0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    pc            = 32'h0000_1000;
    in_shadow     = 1'b0;
    next_valid    = 1'b0;
    next_redirect = 1'b0;
    cur_valid     = 1'b0;
    cur_redirect  = 1'b0;
    armed         = 1'b0;
    check_count   = 0;
    error_count   = 0;
    test_count    = 0;
    last_checks   = 0;
    last_errors   = 0;
    cycle_count   = 0;

    wait (reset === 1'b1);
    check_value("result_valid after reset", 32'(result_valid), 32'd0);
    check_value("redirect after reset", 32'(redirect), 32'd0);
    check_value("stall after reset", 32'(stall), 32'd0);
    issue_instr(op_or, 5'd7, 5'd9, 5'd3, '0, 1'b0);  // cleared registers give zero
    report_test("reset");

    for (int i = 1; i < 32; i++) begin
      issue_instr(op_add, 5'd0, 5'd0, reg_addr_t'(i), word_t'($urandom), 1'b1);
    end
    for (int i = 0; i < RANDOM_OPS; i++) begin
      issue_instr(op_t'(5'($urandom_range(0, 10))), reg_addr_t'($urandom_range(0, 31)),
                  reg_addr_t'($urandom_range(0, 31)), reg_addr_t'($urandom_range(0, 31)),
                  word_t'($urandom), 1'($urandom_range(0, 1)));
    end
    report_test("random alu");

    for (int i = 0; i < FWD_ROUNDS; i++) begin
      prod = reg_addr_t'($urandom_range(1, 30));
      cons = prod + 5'd1;
      issue_instr(op_add, 5'd0, 5'd0, prod, word_t'($urandom), 1'b1);
      issue_instr(op_xor, prod, 5'd0, cons, word_t'($urandom), 1'b1);
      // prod two cycles back, cons one cycle back
      issue_instr(op_sub, prod, cons, reg_addr_t'($urandom_range(1, 31)), '0, 1'b0);
    end
    report_test("forwarding");

    for (int i = 0; i < BRANCH_ROUNDS; i++) begin
      bop       = op_t'(5'(11 + $urandom_range(0, 4)));  // jal or one of the branches
      src       = reg_addr_t'($urandom_range(1, 4));
      shadow_rd = reg_addr_t'($urandom_range(5, 31));
      shadow_op = ($urandom_range(0, 1) == 0) ? op_add : op_divu;
      issue_instr(bop, src, reg_addr_t'($urandom_range(1, 4)),
                  reg_addr_t'($urandom_range(5, 31)),
                  (word_t'($urandom_range(0, 511)) << 2) - 32'd1024, 1'b0);
      issue_instr(shadow_op, src, 5'd0, shadow_rd, word_t'($urandom), 1'b1);
      issue_instr(op_or, shadow_rd, 5'd0, reg_addr_t'($urandom_range(5, 31)), '0, 1'b0);
    end
    report_test("branches");

    for (int i = 0; i < DIV_ROUNDS; i++) begin
      if (i < 2) begin
        divisor = '0;
      end else begin
        divisor = word_t'($urandom) >> $urandom_range(0, 31);
      end
      issue_instr(op_add, 5'd0, 5'd0, 5'd20, divisor, 1'b1);
      issue_instr((i % 2 == 0) ? op_divu : op_remu, reg_addr_t'($urandom_range(1, 19)),
                  5'd20, 5'd21, '0, 1'b0);
      issue_instr(op_add, 5'd21, 5'd0, 5'd22, '0, 1'b0);  // consumer of the divide
    end
    report_test("divide");

    $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* execute_top.sv */
`timescale 1ns/1ps

module execute_top import exec_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      issue_valid,
  input  op_t       issue_op,
  input  reg_addr_t issue_rs1,
  input  reg_addr_t issue_rs2,
  input  reg_addr_t issue_rd,
  input  word_t     issue_imm,
  input  word_t     issue_pc,
  input  logic      issue_use_imm,
  output logic      result_valid,
  output reg_addr_t result_rd,
  output word_t     result_data,
  output logic      redirect,
  output word_t     redirect_pc,
  output logic      stall
);

  word_t file_data_a;
  word_t file_data_b;
  word_t operand_a;
  word_t operand_b;
  word_t unit_b;
  word_t alu_result;
  logic  branch_taken;
  word_t branch_target;
  logic  div_start;
  logic  div_ready;
  word_t div_quotient;
  word_t div_remainder;

  register_file u_regs (
    .clock        (clock),
    .reset        (reset),
    .read_addr_a  (issue_rs1),
    .read_addr_b  (issue_rs2),
    .read_data_a  (file_data_a),
    .read_data_b  (file_data_b),
    .write_enable (result_valid),  // written back from the pipeline register
    .write_addr   (result_rd),
    .write_data   (result_data)
  );

  forwarding u_fwd (
    .rs1         (issue_rs1),
    .rs2         (issue_rs2),
    .file_data_a (file_data_a),
    .file_data_b (file_data_b),
    .fwd_valid   (result_valid),
    .fwd_rd      (result_rd),
    .fwd_data    (result_data),
    .operand_a   (operand_a),
    .operand_b   (operand_b)
  );

  alu u_alu (
    .op        (issue_op),
    .operand_a (operand_a),
    .operand_b (unit_b),
    .pc        (issue_pc),
    .result    (alu_result)
  );

  branch_unit u_branch (
    .op        (issue_op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .pc        (issue_pc),
    .imm       (issue_imm),
    .taken     (branch_taken),
    .target    (branch_target)
  );

  divider u_div (
    .clock     (clock),
    .reset     (reset),
    .start     (div_start),
    .dividend  (operand_a),
    .divisor   (unit_b),
    .quotient  (div_quotient),
    .remainder (div_remainder),
    .ready     (div_ready)
  );

  execute_stage u_stage (
    .clock         (clock),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_rd      (issue_rd),
    .issue_imm     (issue_imm),
    .issue_pc      (issue_pc),
    .issue_use_imm (issue_use_imm),
    .operand_a     (operand_a),
    .operand_b     (operand_b),
    .alu_result    (alu_result),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .div_quotient  (div_quotient),
    .div_remainder (div_remainder),
    .div_ready     (div_ready),
    .div_start     (div_start),
    .unit_b        (unit_b),
    .result_valid  (result_valid),
    .result_rd     (result_rd),
    .result_data   (result_data),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .stall         (stall)
  );

endmodule

/* forwarding.sv */
`timescale 1ns/1ps

module forwarding import exec_pkg::*; (
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  word_t     file_data_a,
  input  word_t     file_data_b,
  input  logic      fwd_valid,
  input  reg_addr_t fwd_rd,
  input  word_t     fwd_data,
  output word_t     operand_a,
  output word_t     operand_b
);

  logic hit_a;
  logic hit_b;

  // last cycle's result is not in the file yet
  assign hit_a = fwd_valid && (fwd_rd != '0) && (fwd_rd == rs1);
  assign hit_b = fwd_valid && (fwd_rd != '0) && (fwd_rd == rs2);

  assign operand_a = hit_a ? fwd_data : file_data_a;
  assign operand_b = hit_b ? fwd_data : file_data_b;

endmodule

/* register_file.sv */
`timescale 1ns/1ps

module register_file import exec_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  reg_addr_t read_addr_a,
  input  reg_addr_t read_addr_b,
  output word_t     read_data_a,
  output word_t     read_data_b,
  input  logic      write_enable,
  input  reg_addr_t write_addr,
  input  word_t     write_data
);

  word_t regs [32];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && (write_addr != '0)) begin
      regs[write_addr] <= write_data;  // x0 stays zero
    end
  end

  // combinational read
  assign read_data_a = (read_addr_a == '0) ? '0 : regs[read_addr_a];
  assign read_data_b = (read_addr_b == '0) ? '0 : regs[read_addr_b];

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    reset = 1'b0;  // active low
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
  end

  always #5 clock = ~clock;

endmodule
